// ==== list.f ====
+incdir+src
src/sl_pkg.sv
src/obi_phase_monitor.sv
src/obi_attr_fifo.sv
src/obi_bus_observer.sv
src/core_event_tracker.sv
src/support_logic_top.sv
tests/sl_asserts.sv
tests/tb_support_logic.sv

// ==== tests/tb_support_logic.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "sl_params.svh"

module tb_support_logic;

  import sl_pkg::*;

  localparam int MAX_TX = 32;
  localparam int MAX_EV = 96;
  // ring size for in-flight responses, above the fifo depth
  localparam int RING   = 16;

  logic         in_support_if;
  logic         arst_n_i;
  obi_bus_t     instr_bus;
  obi_bus_t     data_bus;
  instr_attr_t  instr_attr;
  data_attr_t   data_attr;
  retire_t      retire;
  trap_t        trap;
  logic         fetch_enable;
  logic         debug_req;
  bus_flags_t   instr_flags;
  bus_flags_t   data_flags;
  instr_attr_t  instr_resp_attr;
  data_attr_t   data_resp_attr;
  core_events_t events;

  // transaction table, one row per bus request
  int         tx_bus   [MAX_TX];
  int         tx_wait  [MAX_TX];
  logic       tx_store [MAX_TX];
  logic       tx_integ [MAX_TX];
  // bad parity at: 0 never, 1 first cycle, 2 grant cycle
  int         tx_bad   [MAX_TX];
  int         tx_dly   [MAX_TX];
  int         n_tx;

  // event table, one row per cycle
  int         ev_sc    [MAX_EV];
  // {fetch_enable, debug_req}
  logic [1:0] ev_ctl   [MAX_EV];
  logic [3:0] ev_ret   [MAX_EV];
  logic [1:0] ev_trap  [MAX_EV];
  // data bus {req, gnt}
  logic [1:0] ev_dbus  [MAX_EV];
  // {first_fetch, first_debug_ins, recorded_dbg_req, req_after_exception}
  logic [3:0] ev_exp   [MAX_EV];
  int         n_ev;

  // responder model state, index 0 instr, 1 data
  int         cur_row  [2];
  int         cur_cyc  [2];
  logic       err_acc  [2];
  logic       prev_wait[2];
  int         cnt      [2];
  int         next_row [2];
  int         last_due [2];
  int         rq_row   [2][RING];
  int         rq_due   [2][RING];
  logic [2:0] rq_attr  [2][RING];
  int         rq_head  [2];
  int         rq_tail  [2];
  int         row_err0 [MAX_TX];
  obi_bus_t   drv      [2];
  logic [2:0] drv_attr [2];
  int         bus_cyc;

  // error counts per group, 2 is everything off the buses
  int         grp_err  [3];
  int         err_cnt;
  int         test_cnt;
  int         fail_cnt;
  int         cyc_cnt;
  int         cyc_limit;
  int         seed_val;

  support_logic_top dut0 (
    .in_support_if     (in_support_if),
    .arst_n_i          (arst_n_i),
    .instr_bus_i       (instr_bus),
    .data_bus_i        (data_bus),
    .instr_attr_i      (instr_attr),
    .data_attr_i       (data_attr),
    .retire_i          (retire),
    .trap_i            (trap),
    .fetch_enable_i    (fetch_enable),
    .debug_req_i       (debug_req),
    .instr_flags_o     (instr_flags),
    .data_flags_o      (data_flags),
    .instr_resp_attr_o (instr_resp_attr),
    .data_resp_attr_o  (data_resp_attr),
    .events_o          (events)
  );

  bind obi_attr_fifo sl_asserts #(
    .DEPTH  (DEPTH)
  ) u_fifo_asserts (
    .in_support_if (in_support_if),
    .arst_n_i      (arst_n_i),
    .bus_i         (bus_i),
    .fill_i        (fill_q),
    .wr_ptr_i      (wr_ptr_q),
    .rd_ptr_i      (rd_ptr_q)
  );

  initial begin
    in_support_if = 1'b0;
    forever begin
      #20 in_support_if = ~in_support_if;
    end
  end

  // watchdog
  always @(posedge in_support_if) begin
    cyc_cnt = cyc_cnt + 1;
    if (cyc_limit > 0 && cyc_cnt > cyc_limit) begin
      $display("timeout: run still going after %0d cycles", cyc_limit);
      $display("TEST FAILED");
      $finish;
    end
  end

  // --------------------------------------------------
  // helpers
  // --------------------------------------------------

  task automatic add_tx(input int bus, input int wt, input logic st, input logic ig,
                        input int bad, input int dly);
    tx_bus[n_tx]   = bus;
    tx_wait[n_tx]  = wt;
    tx_store[n_tx] = st;
    tx_integ[n_tx] = ig;
    tx_bad[n_tx]   = bad;
    tx_dly[n_tx]   = dly;
    n_tx++;
  endtask

  task automatic add_ev(input int sc, input logic [1:0] ctl, input logic [3:0] ret,
                        input logic [1:0] trp, input logic [1:0] dbus,
                        input logic [3:0] exp);
    ev_sc[n_ev]   = sc;
    ev_ctl[n_ev]  = ctl;
    ev_ret[n_ev]  = ret;
    ev_trap[n_ev] = trp;
    ev_dbus[n_ev] = dbus;
    ev_exp[n_ev]  = exp;
    n_ev++;
  endtask

  task automatic compare(input string name, input int got, input int exp, input int grp);
    if (got != exp) begin
      $display("** Error at %0t: %s is %0h, expected %0h", $time, name, got, exp);
      err_cnt++;
      grp_err[grp]++;
    end
  endtask

  task automatic report_test(input string name, input bit ok);
    test_cnt++;
    if (ok) begin
      $display("test %s: ok", name);
    end else begin
      fail_cnt++;
      $display("test %s: failed", name);
    end
  endtask

  task automatic drive_idle();
    instr_bus        = '0;
    instr_bus.gntpar = 1'b1;
    data_bus         = '0;
    data_bus.gntpar  = 1'b1;
    instr_attr       = '0;
    data_attr        = '0;
    retire           = '0;
    trap             = '0;
    fetch_enable     = 1'b0;
    debug_req        = 1'b0;
  endtask

  // reset held for 4 cycles, released on a falling edge
  task automatic reset_dut();
    @(negedge in_support_if);
    drive_idle();
    arst_n_i = 1'b0;
    repeat (4) @(negedge in_support_if);
    arst_n_i = 1'b1;
  endtask

  task automatic check_reset_state();
    int err0;
    err0 = err_cnt;
    #1;
    compare("instr_flags_o", instr_flags, 0, 2);
    compare("data_flags_o", data_flags, 0, 2);
    compare("instr_resp_attr_o", instr_resp_attr, 0, 2);
    compare("data_resp_attr_o", data_resp_attr, 0, 2);
    compare("events_o", events, 0, 2);
    report_test("reset state", err_cnt == err0);
  endtask

  function automatic int find_next(input int b, input int from);
    int k;
    k = from;
    while (k < n_tx && tx_bus[k] != b) begin
      k++;
    end
    return k;
  endfunction

  function automatic bit bus_idle();
    bit idle;
    idle = 1'b1;
    for (int b = 0; b < 2; b++) begin
      if (next_row[b] < n_tx || cur_row[b] >= 0 || rq_head[b] != rq_tail[b]) begin
        idle = 1'b0;
      end
    end
    return idle;
  endfunction

  // --------------------------------------------------
  // responder model
  // --------------------------------------------------

  // pick this cycle's pins for bus b
  task automatic plan_bus(input int b);
    int   r;
    logic gnt;
    logic bad;
    r = cur_row[b];
    // a new request only while the fifo has room
    if (r < 0 && next_row[b] < n_tx && rq_tail[b] - rq_head[b] < `SL_MAX_OUTSTANDING) begin
      r           = next_row[b];
      cur_row[b]  = r;
      cur_cyc[b]  = 0;
      err_acc[b]  = 1'b0;
      row_err0[r] = grp_err[b];
      next_row[b] = find_next(b, r + 1);
    end
    drv[b] = '0;
    if (r >= 0) begin
      gnt            = (cur_cyc[b] == tx_wait[r]);
      bad            = (tx_bad[r] == 1 && cur_cyc[b] == 0) || (tx_bad[r] == 2 && gnt);
      drv[b].req     = 1'b1;
      drv[b].gnt     = gnt;
      // parity ok when gntpar is the inverse of gnt
      drv[b].gntpar  = bad ? gnt : ~gnt;
      err_acc[b]     = err_acc[b] | bad;
      // gntpar_err input bit is random, the dut must ignore it
      drv_attr[b]    = {tx_store[r] & (b == 1), tx_integ[r], 1'($urandom)};
    end else begin
      drv[b].gntpar  = 1'b1;
      drv_attr[b]    = 3'($urandom);
    end
    drv[b].rvalid = (rq_head[b] != rq_tail[b]) && (rq_due[b][rq_head[b] % RING] == bus_cyc);
  endtask

  task automatic check_bus(input int b);
    bus_flags_t f;
    logic [2:0] got_attr;
    logic [2:0] exp_attr;
    string      pfx;
    f        = (b == 0) ? instr_flags : data_flags;
    got_attr = (b == 0) ? {1'b0, instr_resp_attr} : data_resp_attr;
    pfx      = (b == 0) ? "instr" : "data";
    exp_attr = drv[b].rvalid ? rq_attr[b][rq_head[b] % RING] : 3'b000;
    compare({pfx, "_flags_o.addr_ph_cont"}, f.addr_ph_cont, drv[b].req && prev_wait[b], b);
    compare({pfx, "_flags_o.resp_ph_cont"}, f.resp_ph_cont, cnt[b] != 0 && !drv[b].rvalid, b);
    compare({pfx, "_flags_o.v_addr_ph_cnt"}, f.v_addr_ph_cnt, cnt[b], b);
    compare({pfx, "_resp_attr_o"}, got_attr, exp_attr, b);
  endtask

  // model state after the coming rising edge
  task automatic update_bus(input int b);
    int r;
    int r_done;
    int due;
    r            = cur_row[b];
    prev_wait[b] = drv[b].req && !drv[b].gnt;
    if (drv[b].rvalid) begin
      r_done = rq_row[b][rq_head[b] % RING];
      report_test($sformatf("%s tx %0d", (b == 0) ? "instr" : "data", r_done),
                  grp_err[b] == row_err0[r_done]);
      rq_head[b]++;
      cnt[b]--;
    end
    if (drv[b].gnt) begin
      // responses stay in order, at least one cycle apart
      due = bus_cyc + tx_dly[r];
      if (due <= last_due[b]) begin
        due = last_due[b] + 1;
      end
      last_due[b]                  = due;
      rq_row[b][rq_tail[b] % RING]  = r;
      rq_due[b][rq_tail[b] % RING]  = due;
      rq_attr[b][rq_tail[b] % RING] = {tx_store[r] & (b == 1), tx_integ[r], err_acc[b]};
      rq_tail[b]++;
      cnt[b]++;
      cur_row[b] = -1;
    end else if (r >= 0) begin
      cur_cyc[b]++;
    end
  endtask

  // --------------------------------------------------
  // main sequence
  // --------------------------------------------------

  initial begin
    int i;
    int sc;
    int err0;
    seed_val  = $urandom(22);
    // reset goes low at the first falling edge
    arst_n_i  = 1'b1;
    drive_idle();
    n_tx      = 0;
    n_ev      = 0;
    err_cnt   = 0;
    test_cnt  = 0;
    fail_cnt  = 0;
    cyc_cnt   = 0;
    cyc_limit = 0;
    for (int b = 0; b < 3; b++) begin
      grp_err[b] = 0;
    end

    // bus, waits, store, integrity, bad parity, response delay
    add_tx(1, 0, 1, 1, 0, 2);
    add_tx(1, 2, 0, 1, 1, 1);
    add_tx(1, 3, 1, 0, 2, 3);
    add_tx(1, 0, 1, 0, 0, 6);
    add_tx(1, 0, 0, 1, 0, 1);
    add_tx(1, 0, 1, 1, 1, 1);
    add_tx(1, 0, 0, 0, 0, 1);
    add_tx(1, 1, 1, 1, 0, 2);
    add_tx(0, 0, 0, 1, 0, 1);
    add_tx(0, 1, 0, 0, 1, 2);
    add_tx(0, 0, 0, 1, 0, 5);
    add_tx(0, 0, 0, 0, 2, 1);
    add_tx(0, 0, 0, 1, 0, 1);
    add_tx(0, 0, 0, 0, 0, 1);
    add_tx(0, 2, 0, 1, 0, 1);

    // scenario, {fe, dr}, retire, trap, data {req, gnt}, expected events
    // first fetch, then re-armed by reset
    add_ev(0, 2'b00, 4'b0000, 2'b00, 2'b00, 4'b0000);
    add_ev(0, 2'b10, 4'b0000, 2'b00, 2'b00, 4'b1000);
    add_ev(0, 2'b10, 4'b0000, 2'b00, 2'b00, 4'b0000);
    add_ev(0, 2'b00, 4'b0000, 2'b00, 2'b00, 4'b0000);
    add_ev(0, 2'b10, 4'b0000, 2'b00, 2'b00, 4'b0000);
    add_ev(1, 2'b10, 4'b0000, 2'b00, 2'b00, 4'b1000);
    add_ev(1, 2'b00, 4'b0000, 2'b00, 2'b00, 4'b0000);
    // first debug instruction, dret re-arms, trapping dret does not
    add_ev(2, 2'b00, 4'b1000, 2'b00, 2'b00, 4'b0000);
    add_ev(2, 2'b00, 4'b1100, 2'b00, 2'b00, 4'b0100);
    add_ev(2, 2'b00, 4'b1100, 2'b00, 2'b00, 4'b0000);
    add_ev(2, 2'b00, 4'b0000, 2'b00, 2'b00, 4'b0000);
    add_ev(2, 2'b00, 4'b1100, 2'b00, 2'b00, 4'b0000);
    add_ev(2, 2'b00, 4'b1000, 2'b00, 2'b00, 4'b0000);
    add_ev(2, 2'b00, 4'b1100, 2'b00, 2'b00, 4'b0100);
    add_ev(2, 2'b00, 4'b1110, 2'b00, 2'b00, 4'b0000);
    add_ev(2, 2'b00, 4'b0000, 2'b00, 2'b00, 4'b0000);
    add_ev(2, 2'b00, 4'b1100, 2'b00, 2'b00, 4'b0100);
    add_ev(2, 2'b00, 4'b1111, 2'b00, 2'b00, 4'b0000);
    add_ev(2, 2'b00, 4'b0000, 2'b00, 2'b00, 4'b0000);
    add_ev(2, 2'b00, 4'b1100, 2'b00, 2'b00, 4'b0000);
    // debug request alone, countdown of 2 retires
    add_ev(3, 2'b01, 4'b0000, 2'b00, 2'b00, 4'b0000);
    add_ev(3, 2'b00, 4'b0000, 2'b00, 2'b00, 4'b0010);
    add_ev(3, 2'b00, 4'b1000, 2'b00, 2'b00, 4'b0010);
    add_ev(3, 2'b00, 4'b1000, 2'b00, 2'b00, 4'b0010);
    add_ev(3, 2'b00, 4'b0000, 2'b00, 2'b00, 4'b0010);
    add_ev(3, 2'b00, 4'b1000, 2'b00, 2'b00, 4'b0010);
    add_ev(3, 2'b00, 4'b0000, 2'b00, 2'b00, 4'b0000);
    // debug request with a retire, countdown of 1
    add_ev(4, 2'b01, 4'b1000, 2'b00, 2'b00, 4'b0000);
    add_ev(4, 2'b00, 4'b1000, 2'b00, 2'b00, 4'b0010);
    add_ev(4, 2'b00, 4'b1000, 2'b00, 2'b00, 4'b0010);
    add_ev(4, 2'b00, 4'b0000, 2'b00, 2'b00, 4'b0000);
    // data request right at the trap edge
    add_ev(5, 2'b00, 4'b0000, 2'b00, 2'b11, 4'b0000);
    add_ev(5, 2'b00, 4'b0000, 2'b11, 2'b10, 4'b0000);
    add_ev(5, 2'b00, 4'b0000, 2'b00, 2'b00, 4'b0001);
    add_ev(5, 2'b00, 4'b1000, 2'b00, 2'b00, 4'b0001);
    add_ev(5, 2'b00, 4'b0000, 2'b00, 2'b00, 4'b0000);
    // data request while the trap is pending, none once retired
    add_ev(6, 2'b00, 4'b0000, 2'b11, 2'b00, 4'b0000);
    add_ev(6, 2'b00, 4'b0000, 2'b00, 2'b11, 4'b0000);
    add_ev(6, 2'b00, 4'b0000, 2'b00, 2'b10, 4'b0000);
    add_ev(6, 2'b00, 4'b0000, 2'b00, 2'b00, 4'b0001);
    add_ev(6, 2'b00, 4'b1000, 2'b00, 2'b00, 4'b0001);
    add_ev(6, 2'b00, 4'b0000, 2'b00, 2'b11, 4'b0000);
    add_ev(6, 2'b00, 4'b0000, 2'b00, 2'b10, 4'b0000);
    add_ev(6, 2'b00, 4'b0000, 2'b00, 2'b00, 4'b0000);
    // pc set that is no trap
    add_ev(7, 2'b00, 4'b0000, 2'b00, 2'b11, 4'b0000);
    add_ev(7, 2'b00, 4'b0000, 2'b10, 2'b10, 4'b0000);
    add_ev(7, 2'b00, 4'b0000, 2'b00, 2'b00, 4'b0000);

    // limit from the table lengths, every scenario adds a reset
    cyc_limit = 60;
    for (int k = 0; k < n_tx; k++) begin
      cyc_limit += tx_wait[k] + tx_dly[k] + 2;
    end
    cyc_limit += n_ev * 7;

    for (int b = 0; b < 2; b++) begin
      cur_row[b]   = -1;
      cur_cyc[b]   = 0;
      err_acc[b]   = 1'b0;
      prev_wait[b] = 1'b0;
      cnt[b]       = 0;
      last_due[b]  = -1;
      rq_head[b]   = 0;
      rq_tail[b]   = 0;
      next_row[b]  = find_next(b, 0);
    end

    reset_dut();
    check_reset_state();

    // ------------------------------------------------
    // both buses together
    // ------------------------------------------------
    bus_cyc = 0;
    while (!bus_idle()) begin
      @(negedge in_support_if);
      plan_bus(0);
      plan_bus(1);
      instr_bus  = drv[0];
      data_bus   = drv[1];
      instr_attr = drv_attr[0][1:0];
      data_attr  = drv_attr[1];
      #1;
      check_bus(0);
      check_bus(1);
      compare("events_o", events, 0, 2);
      update_bus(0);
      update_bus(1);
      bus_cyc++;
    end

    // ------------------------------------------------
    // event scenarios, each from reset
    // ------------------------------------------------
    i = 0;
    while (i < n_ev) begin
      sc   = ev_sc[i];
      err0 = err_cnt;
      reset_dut();
      check_reset_state();
      while (i < n_ev && ev_sc[i] == sc) begin
        @(negedge in_support_if);
        {fetch_enable, debug_req} = ev_ctl[i];
        retire          = ev_ret[i];
        trap            = ev_trap[i];
        data_bus.req    = ev_dbus[i][1];
        data_bus.gnt    = ev_dbus[i][0];
        data_bus.gntpar = ~ev_dbus[i][0];
        #1;
        compare($sformatf("events_o (scenario %0d row %0d)", sc, i), events, ev_exp[i], 2);
        i++;
      end
      report_test($sformatf("event scenario %0d", sc), err_cnt == err0);
    end

    $display("tests run %0d, tests failed %0d, check errors %0d",
             test_cnt, fail_cnt, err_cnt);
    if (err_cnt == 0 && fail_cnt == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== tests/sl_asserts.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "sl_params.svh"

module sl_asserts #(
  parameter int DEPTH  = `SL_MAX_OUTSTANDING,
  parameter int PTR_W  = (DEPTH > 1) ? $clog2(DEPTH) : 1,
  parameter int CNT_W  = $clog2(DEPTH + 1)
) (
  input logic              in_support_if,
  input logic              arst_n_i,
  input sl_pkg::obi_bus_t  bus_i,
  input logic [CNT_W-1:0]  fill_i,
  input logic [PTR_W-1:0]  wr_ptr_i,
  input logic [PTR_W-1:0]  rd_ptr_i
);

  // --------------------------------------------------
  // fill level bounds
  // --------------------------------------------------

  // grant without a freeing response needs a free slot
  a_no_overflow: assert property (@(posedge in_support_if) disable iff (!arst_n_i)
    (bus_i.req && bus_i.gnt && !bus_i.rvalid) |-> (fill_i < CNT_W'(DEPTH)))
    else $error("attribute fifo overflow");

  // every response has a stored request
  a_no_underflow: assert property (@(posedge in_support_if) disable iff (!arst_n_i)
    bus_i.rvalid |-> (fill_i != '0))
    else $error("attribute fifo underflow");

  // --------------------------------------------------
  // reset values
  // --------------------------------------------------

  a_reset_vals: assert property (@(posedge in_support_if)
    !arst_n_i |-> (fill_i == '0 && wr_ptr_i == '0 && rd_ptr_i == '0))
    else $error("attribute fifo pointers not cleared in reset");

endmodule

`default_nettype wire

// ==== src/support_logic_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module support_logic_top (
  input  logic                 in_support_if,
  input  logic                 arst_n_i,
  input  sl_pkg::obi_bus_t     instr_bus_i,
  input  sl_pkg::obi_bus_t     data_bus_i,
  input  sl_pkg::instr_attr_t  instr_attr_i,
  input  sl_pkg::data_attr_t   data_attr_i,
  input  sl_pkg::retire_t      retire_i,
  input  sl_pkg::trap_t        trap_i,
  input  logic                 fetch_enable_i,
  input  logic                 debug_req_i,
  output sl_pkg::bus_flags_t   instr_flags_o,
  output sl_pkg::bus_flags_t   data_flags_o,
  output sl_pkg::instr_attr_t  instr_resp_attr_o,
  output sl_pkg::data_attr_t   data_resp_attr_o,
  output sl_pkg::core_events_t events_o
);

  import sl_pkg::*;

  localparam int INSTR_ATTR_W = $bits(instr_attr_t);
  localparam int DATA_ATTR_W  = $bits(data_attr_t);

  logic [INSTR_ATTR_W-2:0] instr_req_attr;
  logic [INSTR_ATTR_W-1:0] instr_resp_attr;
  logic [DATA_ATTR_W-2:0]  data_req_attr;
  logic [DATA_ATTR_W-1:0]  data_resp_attr;

  // --------------------------------------------------
  // bus observers
  // --------------------------------------------------

  // gntpar_err on the inputs is ignored, observers derive it
  assign instr_req_attr = instr_attr_i.integrity;
  assign data_req_attr  = {data_attr_i.store, data_attr_i.integrity};

  obi_bus_observer #(
    .ATTR_W (INSTR_ATTR_W)
  ) u_instr_obs (
    .in_support_if (in_support_if),
    .arst_n_i      (arst_n_i),
    .bus_i         (instr_bus_i),
    .req_attr_i    (instr_req_attr),
    .flags_o       (instr_flags_o),
    .resp_attr_o   (instr_resp_attr)
  );

  obi_bus_observer #(
    .ATTR_W (DATA_ATTR_W)
  ) u_data_obs (
    .in_support_if (in_support_if),
    .arst_n_i      (arst_n_i),
    .bus_i         (data_bus_i),
    .req_attr_i    (data_req_attr),
    .flags_o       (data_flags_o),
    .resp_attr_o   (data_resp_attr)
  );

  // repack, parity error sits in bit 0
  assign instr_resp_attr_o.integrity  = instr_resp_attr[1];
  assign instr_resp_attr_o.gntpar_err = instr_resp_attr[0];
  assign data_resp_attr_o.store       = data_resp_attr[2];
  assign data_resp_attr_o.integrity   = data_resp_attr[1];
  assign data_resp_attr_o.gntpar_err  = data_resp_attr[0];

  // --------------------------------------------------
  // core events
  // --------------------------------------------------

  core_event_tracker u_events (
    .in_support_if  (in_support_if),
    .arst_n_i       (arst_n_i),
    .retire_i       (retire_i),
    .trap_i         (trap_i),
    .data_bus_i     (data_bus_i),
    .fetch_enable_i (fetch_enable_i),
    .debug_req_i    (debug_req_i),
    .events_o       (events_o)
  );

endmodule

`default_nettype wire

// ==== src/core_event_tracker.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "sl_params.svh"

module core_event_tracker (
  input  logic                 in_support_if,
  input  logic                 arst_n_i,
  input  sl_pkg::retire_t      retire_i,
  input  sl_pkg::trap_t        trap_i,
  input  sl_pkg::obi_bus_t     data_bus_i,
  input  logic                 fetch_enable_i,
  input  logic                 debug_req_i,
  output sl_pkg::core_events_t events_o
);

  import sl_pkg::*;

  localparam logic [`SL_DBG_CNT_W-1:0] DBG_CNT_ONE = `SL_DBG_CNT_W'(1);
  localparam logic [`SL_DBG_CNT_W-1:0] DBG_CNT_TWO = `SL_DBG_CNT_W'(2);

  exc_state_e                 exc_state_q;
  // data address phase completed last cycle
  logic                       data_gnt_q;
  logic                       req_after_exc_q;
  // last retire was in debug mode
  logic                       dbg_flag_q;
  // last retire was a dret that did not trap
  logic                       dret_q;
  logic                       enable_seen_q;
  logic                       rec_dbg_req_q;
  logic [`SL_DBG_CNT_W-1:0]   dbg_cnt_q;
  logic                       trap_taken;

  assign trap_taken = trap_i.pc_set && trap_i.is_trap;

  // --------------------------------------------------
  // data request after exception
  // --------------------------------------------------

  // a multi-op instruction must not issue further data requests
  // once one of its sub-ops has trapped
  always_ff @(posedge in_support_if or negedge arst_n_i) begin
    if (!arst_n_i) begin
      exc_state_q     <= EXC_IDLE;
      data_gnt_q      <= 1'b0;
      req_after_exc_q <= 1'b0;
    end else begin
      data_gnt_q <= data_bus_i.gnt;
      if (trap_taken) begin
        if (data_bus_i.req && data_gnt_q) begin
          req_after_exc_q <= 1'b1;
        end
        exc_state_q <= EXC_ACTIVE;
      end else if (retire_i.valid) begin
        exc_state_q     <= EXC_IDLE;
        req_after_exc_q <= 1'b0;
      end else if (exc_state_q == EXC_ACTIVE && data_bus_i.req && data_gnt_q) begin
        req_after_exc_q <= 1'b1;
      end
    end
  end

  // --------------------------------------------------
  // first debug instruction
  // --------------------------------------------------

  always_ff @(posedge in_support_if or negedge arst_n_i) begin
    if (!arst_n_i) begin
      dbg_flag_q <= 1'b0;
      dret_q     <= 1'b0;
    end else begin
      if (retire_i.valid) begin
        dbg_flag_q <= retire_i.dbg_mode;
        if (retire_i.is_dret && !retire_i.trap) begin
          dret_q <= 1'b1;
        end
      end
      // leaving debug, next debug entry counts as first again
      if (dret_q) begin
        dbg_flag_q <= 1'b0;
        dret_q     <= 1'b0;
      end
    end
  end

  // --------------------------------------------------
  // core start
  // --------------------------------------------------

  always_ff @(posedge in_support_if or negedge arst_n_i) begin
    if (!arst_n_i) begin
      enable_seen_q <= 1'b0;
    end else if (fetch_enable_i) begin
      enable_seen_q <= 1'b1;
    end
  end

  // --------------------------------------------------
  // debug request record
  // --------------------------------------------------

  // keep the request visible for long enough that the core could take it
  always_ff @(posedge in_support_if or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rec_dbg_req_q <= 1'b0;
      dbg_cnt_q     <= '0;
    end else if (retire_i.valid) begin
      if (debug_req_i) begin
        rec_dbg_req_q <= 1'b1;
        dbg_cnt_q     <= DBG_CNT_ONE;
      end else if (dbg_cnt_q != '0) begin
        dbg_cnt_q <= dbg_cnt_q - DBG_CNT_ONE;
      end else begin
        rec_dbg_req_q <= 1'b0;
      end
    end else if (debug_req_i) begin
      rec_dbg_req_q <= 1'b1;
      dbg_cnt_q     <= DBG_CNT_TWO;
    end
  end

  // --------------------------------------------------
  // outputs
  // --------------------------------------------------

  assign events_o.first_fetch         = fetch_enable_i && !enable_seen_q;
  assign events_o.first_debug_ins     = retire_i.valid && retire_i.dbg_mode && !dbg_flag_q;
  assign events_o.recorded_dbg_req    = rec_dbg_req_q;
  assign events_o.req_after_exception = req_after_exc_q;

endmodule

`default_nettype wire

// ==== src/obi_bus_observer.sv ====
`timescale 1ns/1ps
`default_nettype none

module obi_bus_observer #(
  parameter int ATTR_W = 2
) (
  input  logic               in_support_if,
  input  logic               arst_n_i,
  input  sl_pkg::obi_bus_t   bus_i,
  // attribute bits above gntpar_err
  input  logic [ATTR_W-2:0]  req_attr_i,
  output sl_pkg::bus_flags_t flags_o,
  output logic [ATTR_W-1:0]  resp_attr_o
);

  // --------------------------------------------------
  // grant parity
  // --------------------------------------------------

  // mismatch seen in an earlier waiting cycle of this request
  logic              gntpar_sticky_q;
  logic              gntpar_err;
  logic [ATTR_W-1:0] push_attr;

  // gntpar equal to gnt is a parity error
  // once seen, the error stays with the request until granted
  assign gntpar_err = bus_i.req && ((bus_i.gnt == bus_i.gntpar) || gntpar_sticky_q);

  always_ff @(posedge in_support_if or negedge arst_n_i) begin
    if (!arst_n_i) begin
      gntpar_sticky_q <= 1'b0;
    end else if (bus_i.req && !bus_i.gnt) begin
      // still waiting, carry the error forward
      gntpar_sticky_q <= gntpar_err;
    end else begin
      // granted or idle, next request starts clean
      gntpar_sticky_q <= 1'b0;
    end
  end

  // error value at the granting edge goes in as the lowest bit
  assign push_attr = {req_attr_i, gntpar_err};

  // --------------------------------------------------
  // submodules
  // --------------------------------------------------

  obi_phase_monitor u_phase_mon (
    .in_support_if (in_support_if),
    .arst_n_i      (arst_n_i),
    .bus_i         (bus_i),
    .flags_o       (flags_o)
  );

  // in-order responses pick up the attributes of their request
  obi_attr_fifo #(
    .ATTR_W (ATTR_W)
  ) u_attr_fifo (
    .in_support_if (in_support_if),
    .arst_n_i      (arst_n_i),
    .bus_i         (bus_i),
    .attr_i        (push_attr),
    .attr_o        (resp_attr_o)
  );

endmodule

`default_nettype wire

// ==== src/obi_attr_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "sl_params.svh"

module obi_attr_fifo #(
  parameter int ATTR_W = 1,
  parameter int DEPTH  = `SL_MAX_OUTSTANDING
) (
  input  logic              in_support_if,
  input  logic              arst_n_i,
  input  sl_pkg::obi_bus_t  bus_i,
  input  logic [ATTR_W-1:0] attr_i,
  output logic [ATTR_W-1:0] attr_o
);

  // pointer needs at least one bit even for a single entry
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);
  localparam logic [PTR_W-1:0] LAST_IDX = PTR_W'(DEPTH - 1);
  localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(DEPTH);

  logic [ATTR_W-1:0] mem_q [DEPTH];
  logic [PTR_W-1:0]  wr_ptr_q;
  logic [PTR_W-1:0]  rd_ptr_q;
  logic [CNT_W-1:0]  fill_q;
  logic              full;
  logic              empty;
  logic              push;
  logic              pop;

  assign full  = (fill_q == FULL_CNT);
  assign empty = (fill_q == '0);

  // push on a completed address phase
  // a full fifo only accepts when a response frees a slot
  assign push = bus_i.req && bus_i.gnt && (!full || pop);
  // rvalid never pairs with its own grant, so the head is
  // already stored when the response arrives
  assign pop  = bus_i.rvalid && !empty;

  // --------------------------------------------------
  // storage, no reset needed on payload
  // --------------------------------------------------

  always_ff @(posedge in_support_if) begin
    if (push) begin
      mem_q[wr_ptr_q] <= attr_i;
    end
  end

  // --------------------------------------------------
  // pointers and fill level
  // --------------------------------------------------

  always_ff @(posedge in_support_if or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      fill_q   <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == LAST_IDX) ? '0 : wr_ptr_q + PTR_W'(1);
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == LAST_IDX) ? '0 : rd_ptr_q + PTR_W'(1);
      end
      case ({push, pop})
        2'b10:   fill_q <= fill_q + CNT_W'(1);
        2'b01:   fill_q <= fill_q - CNT_W'(1);
        default: fill_q <= fill_q;
      endcase
    end
  end

  // head shown only during the response cycle
  assign attr_o = pop ? mem_q[rd_ptr_q] : '0;

endmodule

`default_nettype wire

// ==== src/obi_phase_monitor.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "sl_params.svh"

module obi_phase_monitor (
  input  logic               in_support_if,
  input  logic               arst_n_i,
  input  sl_pkg::obi_bus_t   bus_i,
  output sl_pkg::bus_flags_t flags_o
);

  import sl_pkg::*;

  // counter ceiling, keeps a misbehaving bus from wrapping the count
  localparam outst_cnt_t CNT_MAX = {`SL_CNT_W{1'b1}};

  // request was waiting for grant last cycle
  logic       wait_q;
  outst_cnt_t cnt_q;
  // address phase completes this cycle
  logic       addr_done;

  assign addr_done = bus_i.req && bus_i.gnt;

  // --------------------------------------------------
  // registered state
  // --------------------------------------------------

  always_ff @(posedge in_support_if or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wait_q <= 1'b0;
      cnt_q  <= '0;
    end else begin
      wait_q <= bus_i.req && !bus_i.gnt;
      // grant and rvalid in one cycle cancel out
      if (addr_done && !bus_i.rvalid) begin
        if (cnt_q != CNT_MAX) begin
          cnt_q <= cnt_q + outst_cnt_t'(1);
        end
      end else if (!addr_done && bus_i.rvalid) begin
        if (cnt_q != '0) begin
          cnt_q <= cnt_q - outst_cnt_t'(1);
        end
      end
    end
  end

  // --------------------------------------------------
  // flags
  // --------------------------------------------------

  // address phase held over from an ungranted cycle
  assign flags_o.addr_ph_cont  = bus_i.req && wait_q;
  // responses owed and none arriving now
  assign flags_o.resp_ph_cont  = (cnt_q != '0) && !bus_i.rvalid;
  assign flags_o.v_addr_ph_cnt = cnt_q;

endmodule

`default_nettype wire

// ==== src/sl_pkg.sv ====
`default_nettype none

`include "sl_params.svh"

package sl_pkg;

  // --------------------------------------------------
  // plain vectors with a meaning
  // --------------------------------------------------

  // number of granted requests still waiting for rvalid
  typedef logic [`SL_CNT_W-1:0] outst_cnt_t;

  // --------------------------------------------------
  // bus and core views
  // --------------------------------------------------

  // observed obi pins of one bus
  // gntpar is expected to be the inverse of gnt
  typedef struct packed {
    logic req;
    logic gnt;
    logic rvalid;
    logic gntpar;
  } obi_bus_t;

  // data request attributes, gntpar_err is the lowest bit
  typedef struct packed {
    logic store;
    logic integrity;
    logic gntpar_err;
  } data_attr_t;

  // instruction request attributes
  typedef struct packed {
    logic integrity;
    logic gntpar_err;
  } instr_attr_t;

  // phase flags of one bus
  typedef struct packed {
    logic       addr_ph_cont;
    logic       resp_ph_cont;
    outst_cnt_t v_addr_ph_cnt;
  } bus_flags_t;

  // retirement port, one entry per retired instruction
  typedef struct packed {
    logic valid;
    logic dbg_mode;
    logic is_dret;
    logic trap;
  } retire_t;

  // pc update; is_trap marks an exception or data bus error source
  typedef struct packed {
    logic pc_set;
    logic is_trap;
  } trap_t;

  // event flags for assertion and coverage modules
  typedef struct packed {
    logic first_fetch;
    logic first_debug_ins;
    logic recorded_dbg_req;
    logic req_after_exception;
  } core_events_t;

  // exception tracker states
  typedef enum logic {
    EXC_IDLE,
    EXC_ACTIVE
  } exc_state_e;

endpackage

`default_nettype wire

// ==== src/sl_params.svh ====
`ifndef SL_PARAMS_SVH
`define SL_PARAMS_SVH

// --------------------------------------------------
// support logic sizing
// --------------------------------------------------

// attribute fifo depth, max requests in flight per bus
`define SL_MAX_OUTSTANDING 4

// outstanding request counter width
// must hold SL_MAX_OUTSTANDING without wrapping
`define SL_CNT_W 3

// debug request countdown width, counts retires
`define SL_DBG_CNT_W 2

`endif
